// ==== list.f ====
source/fm_pkg.sv
source/fm_bus_sync.sv
source/fm_mmr.sv
source/fm_timers.sv
source/fm_pg.sv
source/fm_acc.sv
source/fm_chip.sv
test/fm_clk_gen.sv
test/fm_assertions.sv
test/fm_tb.sv

// ==== source/fm_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_acc (
	input  wire logic                        clk_int,
	input  wire logic                        rst,
	input  wire fm_pkg::op_out_t             op,
	output logic signed [fm_pkg::out_w-1:0]  snd_left,
	output logic signed [fm_pkg::out_w-1:0]  snd_right,
	output logic                             sample
);

	localparam int ow = fm_pkg::out_w;
	localparam int mw = fm_pkg::tl_w + 1;

	logic [mw-1:0]        mag;
	logic signed [ow-1:0] amp;
	logic signed [ow-1:0] add_l;
	logic signed [ow-1:0] add_r;
	logic signed [ow-1:0] sum_l;
	logic signed [ow-1:0] sum_r;

	// Square wave of height 127 - tl
	always_comb begin
		mag   = mw'(127) - {1'b0, op.tl};
		amp   = op.sign ? -$signed(ow'(mag)) : $signed(ow'(mag));
		add_l = op.rl[1] ? amp : '0;
		add_r = op.rl[0] ? amp : '0;
	end

	always_ff @(posedge clk_int) begin
		if (rst) begin
			sum_l     <= '0;
			sum_r     <= '0;
			snd_left  <= '0;
			snd_right <= '0;
			sample    <= 1'b0;
		end else begin
			sample <= op.last;
			if (op.last) begin
				// Close the frame and start a fresh sum
				snd_left  <= sum_l + add_l;
				snd_right <= sum_r + add_r;
				sum_l     <= '0;
				sum_r     <= '0;
			end else begin
				sum_l <= sum_l + add_l;
				sum_r <= sum_r + add_r;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/fm_bus_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_bus_sync (
	input  wire logic            clk_int,
	input  wire logic            rst,
	input  wire logic [7:0]      din,
	input  wire logic            addr,
	input  wire logic            cs_n,
	input  wire logic            wr_n,
	input  wire logic            busy,
	input  wire logic            flag_a,
	input  wire logic            flag_b,
	output fm_pkg::bus_req_t     req,
	output logic [7:0]           dout
);

	logic wr_act;
	logic wr_act_q;

	// Write strobe is active only with chip select
	assign wr_act = ~cs_n & ~wr_n;

	always_ff @(posedge clk_int) begin
		if (rst) begin
			wr_act_q <= 1'b0;
		end else begin
			wr_act_q <= wr_act;
		end
	end

	// One request per low pulse of wr_n
	always_ff @(posedge clk_int) begin
		if (rst) begin
			req <= '0;
		end else begin
			req.write <= wr_act & ~wr_act_q;
			req.addr  <= addr;
			req.data  <= din;
		end
	end

	// Status byte, busy on top and timer flags at the bottom
	always_ff @(posedge clk_int) begin
		if (rst) begin
			dout <= 8'h00;
		end else begin
			dout <= {busy, 5'b00000, flag_b, flag_a};
		end
	end

endmodule

`default_nettype wire

// ==== source/fm_chip.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_chip #(
	parameter int ch_count = 4
) (
	input  wire logic                       clk_int,
	input  wire logic                       rst,
	input  wire logic [7:0]                 din,
	input  wire logic                       addr,
	input  wire logic                       cs_n,
	input  wire logic                       wr_n,
	output logic [7:0]                      dout,
	output logic signed [fm_pkg::out_w-1:0] snd_left,
	output logic signed [fm_pkg::out_w-1:0] snd_right,
	output logic                            sample,
	output logic                            irq_n
);

	fm_pkg::bus_req_t   req;
	fm_pkg::slot_t      slot;
	fm_pkg::timer_ctl_t tctl;
	fm_pkg::op_out_t    op;
	logic               busy;
	logic               frame;
	logic               flag_a;
	logic               flag_b;

	fm_bus_sync u_bus_sync (
		.clk_int (clk_int),
		.rst     (rst),
		.din     (din),
		.addr    (addr),
		.cs_n    (cs_n),
		.wr_n    (wr_n),
		.busy    (busy),
		.flag_a  (flag_a),
		.flag_b  (flag_b),
		.req     (req),
		.dout    (dout)
	);

	fm_mmr #(.ch_count(ch_count)) u_mmr (
		.clk_int (clk_int),
		.rst     (rst),
		.req     (req),
		.busy    (busy),
		.slot    (slot),
		.frame   (frame),
		.tctl    (tctl)
	);

	fm_timers u_timers (
		.clk_int (clk_int),
		.rst     (rst),
		.frame   (frame),
		.tctl    (tctl),
		.flag_a  (flag_a),
		.flag_b  (flag_b),
		.irq_n   (irq_n)
	);

	// Slot stream through phase and accumulator stages
	fm_pg #(.ch_count(ch_count)) u_pg (
		.clk_int (clk_int),
		.rst     (rst),
		.slot    (slot),
		.op      (op)
	);

	fm_acc u_acc (
		.clk_int   (clk_int),
		.rst       (rst),
		.op        (op),
		.snd_left  (snd_left),
		.snd_right (snd_right),
		.sample    (sample)
	);

endmodule

`default_nettype wire

// ==== source/fm_mmr.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_mmr #(
	parameter int ch_count = 4
) (
	input  wire logic             clk_int,
	input  wire logic             rst,
	input  wire fm_pkg::bus_req_t req,
	output logic                  busy,
	output fm_pkg::slot_t         slot,
	output logic                  frame,
	output fm_pkg::timer_ctl_t    tctl
);

	localparam int aw = $clog2(ch_count);
	localparam int iw = fm_pkg::slot_idx_w;
	localparam logic [iw-1:0] last_slot = iw'(ch_count - 1);

	fm_pkg::mmr_state_e  state;
	logic [1:0]          hold_cnt;
	logic [7:0]          sel;
	logic                data_wr;
	logic [7:0]          off_tl;
	logic [7:0]          off_flo;
	logic [7:0]          off_fhi;
	logic [7:0]          off_pan;
	fm_pkg::ch_cfg_t     pend [ch_count];
	fm_pkg::ch_cfg_t     act [ch_count];
	logic [ch_count-1:0] rst_pend;
	logic [ch_count-1:0] rst_act;
	logic [iw-1:0]       cnt;

	assign busy    = (state == fm_pkg::busy_hold);
	assign data_wr = req.write & req.addr & (state == fm_pkg::data_wait);

	// Channel offsets within each register group
	assign off_tl  = sel - 8'(fm_pkg::tl_base);
	assign off_flo = sel - 8'(fm_pkg::fnum_lo_base);
	assign off_fhi = sel - 8'(fm_pkg::fnum_hi_base);
	assign off_pan = sel - 8'(fm_pkg::pan_base);

	// Address then data, busy for four cycles after each data write
	always_ff @(posedge clk_int) begin
		if (rst) begin
			state    <= fm_pkg::idle;
			hold_cnt <= 2'd0;
			sel      <= 8'h00;
		end else begin
			case (state)
				fm_pkg::idle: begin
					if (req.write && !req.addr) begin
						sel   <= req.data;
						state <= fm_pkg::data_wait;
					end
				end
				fm_pkg::data_wait: begin
					if (req.write && !req.addr) begin
						sel <= req.data;
					end else if (req.write) begin
						hold_cnt <= 2'd0;
						state    <= fm_pkg::busy_hold;
					end
				end
				fm_pkg::busy_hold: begin
					hold_cnt <= hold_cnt + 2'd1;
					if (hold_cnt == 2'd3)
						state <= fm_pkg::data_wait;
				end
				default: state <= fm_pkg::idle;
			endcase
		end
	end

	// Timer settings, clear bits are single-cycle pulses
	always_ff @(posedge clk_int) begin
		if (rst) begin
			tctl <= '0;
		end else begin
			tctl.clr_a <= 1'b0;
			tctl.clr_b <= 1'b0;
			if (data_wr) begin
				case (sel)
					fm_pkg::timer_a_hi: tctl.value_a[9:2] <= req.data;
					fm_pkg::timer_a_lo: tctl.value_a[1:0] <= req.data[1:0];
					fm_pkg::timer_b:    tctl.value_b      <= req.data;
					fm_pkg::timer_ctl: begin
						tctl.run_a <= req.data[0];
						tctl.run_b <= req.data[1];
						tctl.en_a  <= req.data[2];
						tctl.en_b  <= req.data[3];
						tctl.clr_a <= req.data[4];
						tctl.clr_b <= req.data[5];
					end
					default: ;
				endcase
			end
		end
	end

	// Slot counter, pending channel copy and frame swap
	always_ff @(posedge clk_int) begin
		if (rst) begin
			for (int i = 0; i < ch_count; i++) begin
				pend[i] <= '0;
				act[i]  <= '0;
			end
			rst_pend <= '0;
			rst_act  <= '0;
			cnt      <= '0;
		end else begin
			cnt <= (cnt == last_slot) ? '0 : cnt + 1'b1;
			if (cnt == last_slot) begin
				act      <= pend;
				rst_act  <= rst_pend;
				rst_pend <= '0;
			end
			// Writes after the swap land in the following frame
			if (data_wr) begin
				if (off_tl < ch_count)
					pend[off_tl[aw-1:0]].tl <= req.data[6:0];
				if (off_flo < ch_count) begin
					pend[off_flo[aw-1:0]].fnum[7:0] <= req.data;
					rst_pend[off_flo[aw-1:0]]       <= 1'b1;
				end
				if (off_fhi < ch_count) begin
					pend[off_fhi[aw-1:0]].block      <= req.data[5:3];
					pend[off_fhi[aw-1:0]].fnum[10:8] <= req.data[2:0];
					rst_pend[off_fhi[aw-1:0]]        <= 1'b1;
				end
				if (off_pan < ch_count)
					pend[off_pan[aw-1:0]].rl <= req.data[7:6];
			end
		end
	end

	always_comb begin
		slot.cfg    = act[cnt[aw-1:0]];
		slot.idx    = cnt;
		slot.ph_rst = rst_act[cnt[aw-1:0]];
		slot.last   = (cnt == last_slot);
	end

	// Frame pulse rides along with slot 0
	assign frame = (cnt == '0);

endmodule

`default_nettype wire

// ==== source/fm_pg.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_pg #(
	parameter int ch_count = 4
) (
	input  wire logic          clk_int,
	input  wire logic          rst,
	input  wire fm_pkg::slot_t slot,
	output fm_pkg::op_out_t    op
);

	localparam int aw = $clog2(ch_count);
	localparam int pw = fm_pkg::phase_w;

	logic [pw-1:0] phase_mem [ch_count];
	logic [pw-1:0] cur;
	logic [pw-1:0] step;
	logic [aw-1:0] ch;

	assign ch = slot.idx[aw-1:0];

	always_comb begin
		cur  = phase_mem[ch];
		// Frequency number scaled by octave
		step = pw'(slot.cfg.fnum) << slot.cfg.block;
	end

	// Read, then write back stepped or cleared phase
	always_ff @(posedge clk_int) begin
		if (rst) begin
			for (int i = 0; i < ch_count; i++)
				phase_mem[i] <= '0;
		end else if (slot.ph_rst) begin
			phase_mem[ch] <= '0;
		end else begin
			phase_mem[ch] <= cur + step;
		end
	end

	// Sign uses the phase from before this frame's step
	always_ff @(posedge clk_int) begin
		if (rst) begin
			op <= '0;
		end else begin
			op.sign <= cur[pw-1];
			op.tl   <= slot.cfg.tl;
			op.rl   <= slot.cfg.rl;
			op.last <= slot.last;
		end
	end

endmodule

`default_nettype wire

// ==== source/fm_pkg.sv ====
`default_nettype none

package fm_pkg;

	// Field widths
	localparam int fnum_w     = 11;
	localparam int block_w    = 3;
	localparam int tl_w       = 7;
	localparam int phase_w    = 20;
	localparam int out_w      = 10;
	// Room for up to 16 channels in the slot index
	localparam int slot_idx_w = 4;

	// Register map, channel registers sit at base + channel
	typedef enum logic [7:0] {
		timer_a_hi   = 8'h24,
		timer_a_lo   = 8'h25,
		timer_b      = 8'h26,
		timer_ctl    = 8'h27,
		tl_base      = 8'h40,
		fnum_lo_base = 8'hA0,
		fnum_hi_base = 8'hA4,
		pan_base     = 8'hB4
	} reg_addr_e;

	typedef enum logic [1:0] {
		idle,
		data_wait,
		busy_hold
	} mmr_state_e;

	typedef struct packed {
		logic       write;
		logic       addr;
		logic [7:0] data;
	} bus_req_t;

	typedef struct packed {
		logic [fnum_w-1:0]  fnum;
		logic [block_w-1:0] block;
		logic [tl_w-1:0]    tl;
		logic [1:0]         rl;
	} ch_cfg_t;

	typedef struct packed {
		ch_cfg_t               cfg;
		logic [slot_idx_w-1:0] idx;
		logic                  ph_rst;
		logic                  last;
	} slot_t;

	typedef struct packed {
		logic            sign;
		logic [tl_w-1:0] tl;
		logic [1:0]      rl;
		logic            last;
	} op_out_t;

	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       run_a;
		logic       run_b;
		logic       en_a;
		logic       en_b;
		logic       clr_a;
		logic       clr_b;
	} timer_ctl_t;

endpackage

`default_nettype wire

// ==== source/fm_timers.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_timers (
	input  wire logic               clk_int,
	input  wire logic               rst,
	input  wire logic               frame,
	input  wire fm_pkg::timer_ctl_t tctl,
	output logic                    flag_a,
	output logic                    flag_b,
	output logic                    irq_n
);

	logic [9:0] cnt_a;
	logic [7:0] cnt_b;
	logic [1:0] pre_b;
	logic       run_a_q;
	logic       run_b_q;
	logic       load_a;
	logic       load_b;
	logic       ov_a;
	logic       ov_b;

	// Start value is loaded on the rising edge of run
	assign load_a = tctl.run_a & ~run_a_q;
	assign load_b = tctl.run_b & ~run_b_q;

	assign ov_a = frame & tctl.run_a & run_a_q & (cnt_a == 10'h3ff);
	// Timer B steps on every fourth frame
	assign ov_b = frame & tctl.run_b & run_b_q & (pre_b == 2'd3) & (cnt_b == 8'hff);

	always_ff @(posedge clk_int) begin
		if (rst) begin
			cnt_a   <= 10'd0;
			cnt_b   <= 8'd0;
			pre_b   <= 2'd0;
			run_a_q <= 1'b0;
			run_b_q <= 1'b0;
		end else begin
			run_a_q <= tctl.run_a;
			run_b_q <= tctl.run_b;

			if (load_a || ov_a)
				cnt_a <= tctl.value_a;
			else if (frame && tctl.run_a)
				cnt_a <= cnt_a + 10'd1;

			if (load_b) begin
				cnt_b <= tctl.value_b;
				pre_b <= 2'd0;
			end else if (frame && tctl.run_b) begin
				pre_b <= pre_b + 2'd1;
				if (ov_b)
					cnt_b <= tctl.value_b;
				else if (pre_b == 2'd3)
					cnt_b <= cnt_b + 8'd1;
			end
		end
	end

	// Overflow beats a clear arriving in the same cycle
	always_ff @(posedge clk_int) begin
		if (rst) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (ov_a && tctl.en_a)
				flag_a <= 1'b1;
			else if (tctl.clr_a)
				flag_a <= 1'b0;

			if (ov_b && tctl.en_b)
				flag_b <= 1'b1;
			else if (tctl.clr_b)
				flag_b <= 1'b0;
		end
	end

	assign irq_n = ~(flag_a | flag_b);

endmodule

`default_nettype wire

// ==== test/fm_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_assertions (
	input wire logic       clk_int,
	input wire logic       rst,
	input wire logic       busy,
	input wire logic [7:0] dout,
	input wire logic       irq_n,
	input wire logic       sample
);

	int fail_count = 0;

	// Status flags show up one cycle after the interrupt pin
	irq_matches_status: assert property (@(posedge clk_int) disable iff (rst)
		(dout[1:0] != 2'b00) == !$past(irq_n))
	else begin
		$error("irq_n does not match the status flags");
		fail_count++;
	end

	// One strobe per frame of four slots
	sample_not_adjacent: assert property (@(posedge clk_int) disable iff (rst)
		sample |=> !sample)
	else begin
		$error("sample strobe on two adjacent cycles");
		fail_count++;
	end

	busy_max_four: assert property (@(posedge clk_int) disable iff (rst)
		busy [*4] |=> !busy)
	else begin
		$error("busy held for more than four cycles");
		fail_count++;
	end

endmodule

bind fm_chip fm_assertions u_assertions (
	.clk_int (clk_int),
	.rst     (rst),
	.busy    (busy),
	.dout    (dout),
	.irq_n   (irq_n),
	.sample  (sample)
);

`default_nettype wire

// ==== test/fm_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_clk_gen #(
	parameter realtime period = 4.0
) (
	output logic clk_int
);

	initial begin
		clk_int = 1'b0;
		forever #(period / 2.0) clk_int = ~clk_int;
	end

endmodule

`default_nettype wire

// ==== test/fm_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fm_tb;

	localparam int ch_count = 4;
	localparam realtime clk_period = 4.0;
	localparam int tl_addr = fm_pkg::tl_base;
	localparam int flo_addr = fm_pkg::fnum_lo_base;
	localparam int fhi_addr = fm_pkg::fnum_hi_base;
	localparam int pan_addr = fm_pkg::pan_base;
	// Run length estimate for the watchdog
	localparam int write_count = 40;
	localparam int write_cycles = 20;
	localparam int strobe_count = 240;
	localparam int run_cycles = write_count * write_cycles + strobe_count * ch_count + 3;

	logic clk_int;
	logic rst;
	logic [7:0] din;
	logic addr;
	logic cs_n;
	logic wr_n;
	logic [7:0] dout;
	logic signed [fm_pkg::out_w-1:0] snd_left;
	logic signed [fm_pkg::out_w-1:0] snd_right;
	logic sample;
	logic irq_n;

	// Reference model state
	fm_pkg::ch_cfg_t model_cfg [ch_count];
	fm_pkg::ch_cfg_t pend_cfg [ch_count];
	logic [ch_count-1:0] model_rst;
	logic [ch_count-1:0] pend_rst;
	logic [19:0] model_phase [ch_count];
	int strobe_idx;
	int apply_at;
	int cycle_idx;
	int last_strobe_cycle;

	fm_clk_gen #(.period(clk_period)) u_clk_gen (
		.clk_int (clk_int)
	);

	fm_chip #(.ch_count(ch_count)) u_dut (
		.clk_int   (clk_int),
		.rst       (rst),
		.din       (din),
		.addr      (addr),
		.cs_n      (cs_n),
		.wr_n      (wr_n),
		.dout      (dout),
		.snd_left  (snd_left),
		.snd_right (snd_right),
		.sample    (sample),
		.irq_n     (irq_n)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopping at the first failure");
	endtask

	task automatic compare(input string name, input int expected, input int actual);
		if (expected != actual)
			report_failure($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
	endtask

	// Predict one frame from the panned square-wave sum
	task automatic check_sample();
		int exp_l;
		int exp_r;
		int mag;
		int amp;
		exp_l = 0;
		exp_r = 0;
		if (strobe_idx == apply_at) begin
			model_cfg = pend_cfg;
			model_rst = pend_rst;
			pend_rst = '0;
		end
		for (int i = 0; i < ch_count; i++) begin
			mag = 127 - int'(model_cfg[i].tl);
			amp = model_phase[i][19] ? -mag : mag;
			if (model_cfg[i].rl[1])
				exp_l += amp;
			if (model_cfg[i].rl[0])
				exp_r += amp;
			// Sign was taken before the reset or step
			if (model_rst[i])
				model_phase[i] = '0;
			else
				model_phase[i] = model_phase[i] + (20'(model_cfg[i].fnum) << model_cfg[i].block);
		end
		model_rst = '0;
		compare($sformatf("left sample %0d", strobe_idx), exp_l, snd_left);
		compare($sformatf("right sample %0d", strobe_idx), exp_r, snd_right);
		strobe_idx++;
	endtask

	task automatic tick();
		@(negedge clk_int);
		cycle_idx++;
		if (sample) begin
			// One strobe per frame of ch_count slots
			if (strobe_idx > 0)
				compare("sample period", ch_count, cycle_idx - last_strobe_cycle);
			last_strobe_cycle = cycle_idx;
			check_sample();
		end
		if (u_dut.u_assertions.fail_count != 0)
			report_failure("A concurrent assertion on the DUT failed");
	endtask

	task automatic wait_strobe();
		tick();
		while (!sample)
			tick();
	endtask

	// Mirror of the pending channel copy, returns 1 for a channel register
	function automatic bit stage_reg(input logic [7:0] ra, input logic [7:0] val);
		int a;
		a = ra;
		if (a >= tl_addr && a < tl_addr + ch_count) begin
			pend_cfg[a - tl_addr].tl = val[6:0];
			return 1'b1;
		end
		if (a >= flo_addr && a < flo_addr + ch_count) begin
			pend_cfg[a - flo_addr].fnum[7:0] = val;
			pend_rst[a - flo_addr] = 1'b1;
			return 1'b1;
		end
		if (a >= fhi_addr && a < fhi_addr + ch_count) begin
			pend_cfg[a - fhi_addr].block = val[5:3];
			pend_cfg[a - fhi_addr].fnum[10:8] = val[2:0];
			pend_rst[a - fhi_addr] = 1'b1;
			return 1'b1;
		end
		if (a >= pan_addr && a < pan_addr + ch_count) begin
			pend_cfg[a - pan_addr].rl = val[7:6];
			return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic bus_pulse(input logic a, input logic [7:0] d);
		cs_n = 1'b0;
		wr_n = 1'b0;
		addr = a;
		din = d;
		tick();
		cs_n = 1'b1;
		wr_n = 1'b1;
		tick();
	endtask

	// Data write right after a strobe, so it reaches the swap two frames on
	task automatic send_data(input logic [7:0] ra, input logic [7:0] val);
		wait_strobe();
		if (stage_reg(ra, val))
			apply_at = strobe_idx + 1;
		bus_pulse(1'b1, val);
	endtask

	task automatic wait_idle();
		repeat (3) tick();
		while (dout[7])
			tick();
	endtask

	task automatic write_reg(input logic [7:0] ra, input logic [7:0] val);
		bus_pulse(1'b0, ra);
		send_data(ra, val);
		wait_idle();
	endtask

	task automatic strobes_to_irq(input int limit, output int count);
		count = 0;
		while (irq_n && count <= limit) begin
			tick();
			if (sample)
				count++;
		end
	endtask

	initial begin
		#(2 * run_cycles * clk_period);
		report_failure("Timeout, the tests did not finish in the expected time");
	end

	initial begin
		int va;
		int vb;
		int lim;
		int cnt;
		logic [7:0] good;
		void'($urandom(32'h4401_9761));
		rst = 1'b1;
		din = 8'h00;
		addr = 1'b0;
		cs_n = 1'b1;
		wr_n = 1'b1;
		strobe_idx = 0;
		apply_at = -1;
		cycle_idx = 0;
		last_strobe_cycle = 0;
		model_rst = '0;
		pend_rst = '0;
		for (int i = 0; i < ch_count; i++) begin
			model_cfg[i] = '0;
			pend_cfg[i] = '0;
			model_phase[i] = '0;
		end
		repeat (3) @(negedge clk_int);
		rst = 1'b0;

		// Quiet outputs after reset
		repeat (4) wait_strobe();
		compare("reset irq_n", 1, irq_n);
		compare("reset status", 0, dout);

		// Random setup of every channel
		for (int ch = 0; ch < ch_count; ch++) begin
			write_reg(8'(tl_addr + ch), 8'($urandom));
			write_reg(8'(flo_addr + ch), 8'($urandom));
			write_reg(8'(fhi_addr + ch), 8'($urandom));
			write_reg(8'(pan_addr + ch), 8'($urandom));
		end
		repeat (64) wait_strobe();

		// Level and pan only, phases keep running
		for (int ch = 0; ch < ch_count; ch++) begin
			write_reg(8'(tl_addr + ch), 8'($urandom));
			write_reg(8'(pan_addr + ch), 8'($urandom));
		end
		repeat (64) wait_strobe();

		// Timer A
		va = $urandom_range(1023, 1000);
		write_reg(8'(fm_pkg::timer_a_hi), 8'(va >> 2));
		write_reg(8'(fm_pkg::timer_a_lo), 8'(va & 3));
		write_reg(8'(fm_pkg::timer_ctl), 8'h05);
		lim = 1024 - va;
		strobes_to_irq(lim + 1, cnt);
		compare("timer A irq_n", 0, irq_n);
		if (cnt < lim - 1 || cnt > lim)
			compare("timer A strobes", lim, cnt);
		tick();
		compare("timer A status", 8'h01, dout);
		write_reg(8'(fm_pkg::timer_ctl), 8'h10);
		compare("timer A cleared irq_n", 1, irq_n);
		compare("timer A cleared status", 0, dout);

		// Timer B with its flag masked, then enabled
		vb = $urandom_range(255, 250);
		write_reg(8'(fm_pkg::timer_b), 8'(vb));
		write_reg(8'(fm_pkg::timer_ctl), 8'h02);
		lim = 4 * (256 - vb) + 8;
		cnt = 0;
		while (cnt < lim) begin
			tick();
			if (sample)
				cnt++;
			compare("timer B masked irq_n", 1, irq_n);
		end
		write_reg(8'(fm_pkg::timer_ctl), 8'h00);
		write_reg(8'(fm_pkg::timer_ctl), 8'h0A);
		lim = 4 * (256 - vb);
		strobes_to_irq(lim + 1, cnt);
		compare("timer B irq_n", 0, irq_n);
		if (cnt < lim - 4 || cnt > lim)
			compare("timer B strobes", lim, cnt);
		tick();
		compare("timer B status", 8'h02, dout);
		write_reg(8'(fm_pkg::timer_ctl), 8'h20);
		compare("timer B cleared irq_n", 1, irq_n);
		compare("timer B cleared status", 0, dout);

		// Second data write lands during busy and must be dropped
		write_reg(8'(pan_addr + 2), 8'hC0);
		good = 8'($urandom);
		bus_pulse(1'b0, 8'(tl_addr + 2));
		send_data(8'(tl_addr + 2), good);
		bus_pulse(1'b1, good ^ 8'h2A);
		wait_idle();
		repeat (8) wait_strobe();

		if (u_dut.u_assertions.fail_count == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			report_failure("A concurrent assertion on the DUT failed");
		end
	end

endmodule

`default_nettype wire
